// ==== dvi_scaler.f ====
src/dvi_timing_pkg.sv
src/video_pixel_pkg.sv
src/video_timing_if.sv
src/chip_timing_table.sv
src/sync_gen.sv
src/line_ram.sv
src/line_double_buffer.sv
src/dvi_scaler_top.sv
test/dvi_scaler_props.sv
test/dvi_scaler_checker.sv
test/tb_dvi_scaler.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator, run, and decide from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_dvi_scaler -f dvi_scaler.f \
    && { ./obj_dir/Vtb_dvi_scaler > sim.log 2>&1 || true; } \
    && cat sim.log \
    && grep -q "all tests passed" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL"; exit 1; }

// ==== test/tb_dvi_scaler.sv ====
// every phase starts from reset; chip, polarity and csync are set only while rst is low
`timescale 1ns/1ps
`default_nettype none

module tb_dvi_scaler import dvi_timing_pkg::*; ();

    logic        clk_dvi;
    logic        rst;
    chip_t       chip;
    logic        hpolarity;
    logic        vpolarity;
    logic        enable_csync;
    logic        pixel_valid;
    logic [9:0]  raster_x;
    logic [3:0]  pixel_color_in;
    logic        hsync;
    logic        vsync;
    logic        active;
    logic [3:0]  pixel_color;
    logic        half_bright;
    logic [2:0]  test_id;       // phase name for error lines
    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          pixel_checks;
    bit          timed_out;

    always #20 clk_dvi = ~clk_dvi;  // 40 ns period

    dvi_scaler_top i_dut (
        .clk_dvi        (clk_dvi),
        .rst            (rst),
        .chip           (chip),
        .hpolarity      (hpolarity),
        .vpolarity      (vpolarity),
        .enable_csync   (enable_csync),
        .pixel_valid    (pixel_valid),
        .raster_x       (raster_x),
        .pixel_color_in (pixel_color_in),
        .hsync          (hsync),
        .vsync          (vsync),
        .active         (active),
        .pixel_color    (pixel_color),
        .half_bright    (half_bright)
    );

    dvi_scaler_checker i_chk (
        .clk_dvi        (clk_dvi),
        .rst            (rst),
        .test_id        (test_id),
        .chip           (chip),
        .hpolarity      (hpolarity),
        .vpolarity      (vpolarity),
        .enable_csync   (enable_csync),
        .pixel_valid    (pixel_valid),
        .raster_x       (raster_x),
        .pixel_color_in (pixel_color_in),
        .hsync          (hsync),
        .vsync          (vsync),
        .active         (active),
        .pixel_color    (pixel_color),
        .half_bright    (half_bright),
        .errors         (errors),
        .checks         (checks),
        .pixel_checks   (pixel_checks)
    );

    // ------------------------------------------------------------
    // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
    // ------------------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    task automatic apply_reset(input chip_t c, input logic hp, input logic vp, input logic cs);
        @(posedge clk_dvi);
        rst          <= 1'b0;
        chip         <= c;
        hpolarity    <= hp;
        vpolarity    <= vp;
        enable_csync <= cs;
        pixel_valid  <= 1'b0;
        repeat (8) @(posedge clk_dvi);
        rst <= 1'b1;
    endtask

    // one toggle of half_bright per output line
    task automatic wait_lines(input int n);
        int   seen;
        int   cycles;
        logic prev;
        seen   = 0;
        cycles = 0;
        prev   = half_bright;
        while (seen < n && !timed_out) begin
            @(posedge clk_dvi);
            cycles++;
            if (half_bright !== prev)
                seen++;
            prev = half_bright;
            if (cycles > n * 1200) begin  // longest line is 945
                $display("timeout: half_bright stopped toggling after %0d of %0d lines", seen, n);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic send_line(input int count);
        logic [15:0] bits;
        for (int x = 0; x < count; x++) begin
            @(posedge clk_dvi);
            take_bits(4, bits);
            pixel_valid    <= 1'b1;
            raster_x       <= 10'(x);
            pixel_color_in <= bits[3:0];
        end
        @(posedge clk_dvi);
        pixel_valid <= 1'b0;
    endtask

    task automatic run_chip(input chip_t c);
        logic [15:0] bits;
        take_bits(2, bits);
        test_id <= 3'd1;
        apply_reset(c, 1'b1, bits[0], 1'b0);
        wait_lines(630);                  // whole frame and the wrap
        test_id <= 3'd2;
        apply_reset(c, 1'b0, ~bits[0], 1'b0);
        wait_lines(60);                   // past every vsync window
        test_id <= 3'd3;
        apply_reset(c, bits[1], 1'b1, 1'b1);
        wait_lines(60);
        test_id <= 3'd4;
        apply_reset(c, bits[1], bits[0], 1'b0);
        send_line(520);
        send_line(1);                     // next native line, swaps buffers
        wait_lines(3);
    endtask

    initial begin
        clk_dvi        = 1'b0;
        rst            = 1'b0;
        chip           = chip_6567r8;
        hpolarity      = 1'b1;
        vpolarity      = 1'b1;
        enable_csync   = 1'b0;
        pixel_valid    = 1'b0;
        raster_x       = '0;
        pixel_color_in = '0;
        test_id        = 3'd0;
        lfsr           = 16'd7;
        timed_out      = 1'b0;
        for (int c = 0; c < 3; c++) begin
            if (!timed_out)
                run_chip(chip_t'(c));
        end
        repeat (2) @(posedge clk_dvi);  // last compares land
        $display("summary: %0d cycles, %0d pixels compared, %0d errors, %0d timeouts",
                 checks, pixel_checks, errors, timed_out);
        if (pixel_checks == 0)
            $display("no readout pixel was compared");
        if (errors == 0 && pixel_checks > 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/dvi_scaler_checker.sv ====
// model assumes chip and sync options change only while rst is low; pixels checked where written
`timescale 1ns/1ps
`default_nettype none

module dvi_scaler_checker (
    input  logic       clk_dvi,
    input  logic       rst,
    input  logic [2:0] test_id,
    input  logic [1:0] chip,
    input  logic       hpolarity,
    input  logic       vpolarity,
    input  logic       enable_csync,
    input  logic       pixel_valid,
    input  logic [9:0] raster_x,
    input  logic [3:0] pixel_color_in,
    input  logic       hsync,
    input  logic       vsync,
    input  logic       active,
    input  logic [3:0] pixel_color,
    input  logic       half_bright,
    output int         errors,
    output int         checks,
    output int         pixel_checks
);

    int         err_count = 0;
    int         cyc_count = 0;
    int         pix_count = 0;
    bit         armed = 1'b0;       // set by the first reset edge
    logic [1:0] chip_q;             // bit 0 = pal
    int         mw, mhgt, hs_sta, hs_end, ha_sta, ha_end;
    int         vs_sta, vs_end, va_sta, va_end, xoff;
    int         mh;                 // model h_count
    int         mv;                 // model v_count
    bit         mhb;
    bit         exp_hs;
    bit         exp_vs;
    bit         exp_act;
    logic [3:0] pipe_pix;           // ram stage
    bit         pipe_ok;
    logic [3:0] exp_pix;            // output register stage
    bit         exp_ok;
    logic [3:0] wr_line [2048];     // native line being filled
    bit         wr_ok   [2048];
    logic [3:0] rd_line [2048];     // line on screen
    bit         rd_ok   [2048];

    assign errors       = err_count;
    assign checks       = cyc_count;
    assign pixel_checks = pix_count;

    task automatic set_window(input int w, input int h, input int hss, input int hse,
                              input int has, input int hae, input int vss, input int vse,
                              input int vas, input int vae, input int off);
        mw     = w;
        mhgt   = h;
        hs_sta = hss;
        hs_end = hse;
        ha_sta = has;
        ha_end = hae;
        vs_sta = vss;
        vs_end = vse;
        va_sta = vas;
        va_end = vae;
        xoff   = off;
    endtask

    task automatic load_timing(input logic [1:0] c);
        chip_q = c;
        if (c[0])         // both 6569 revisions
            set_window(944, 623, 0, 64, 132, 914, 7, 12, 17, 592, 70);
        else if (c == 2'd0)  // 6567r8
            set_window(844, 525, 11, 75, 106, 826, 28, 50, 72, 26, 131);
        else              // 6567r56a
            set_window(831, 523, 2, 66, 90, 814, 28, 50, 70, 26, 139);
    endtask

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd1:    return "frame_sync";
            3'd2:    return "inverted_polarity";
            3'd3:    return "composite_sync";
            3'd4:    return "line_readout";
            default: return "reset";
        endcase
    endfunction

    task automatic check_value(input string sig, input logic [3:0] expv, input logic [3:0] actv);
        if (actv !== expv) begin
            err_count++;
            $display("[ERROR] %s chip %0d %s: expected %0h actual %0h at %0t",
                     test_label(test_id), chip_q, sig, expv, actv, $time);
        end
    endtask

    // ------------------------------------------------------------
    // model stepped on the same edge as the DUT
    // ------------------------------------------------------------
    always @(posedge clk_dvi) begin : model
        int          line_len;
        int          pos;
        bit          hs_on;
        bit          vs_on;
        bit          v_on;
        logic [10:0] addr;
        exp_pix = pipe_pix;  // two-cycle readout
        exp_ok  = pipe_ok;
        if (!rst) begin
            wr_ok = '{default: 1'b0};  // nothing known after reset
            rd_ok = '{default: 1'b0};
        end else if (pixel_valid && raster_x == 10'd0) begin
            rd_line = wr_line;  // finished line goes on screen
            rd_ok   = wr_ok;
            wr_ok   = '{default: 1'b0};
        end
        addr     = 11'(mh + xoff);
        pipe_pix = rd_line[addr];
        pipe_ok  = rd_ok[addr];
        if (rst && pixel_valid) begin
            wr_line[{1'b0, raster_x}] = pixel_color_in;
            wr_ok[{1'b0, raster_x}]   = 1'b1;
        end
        if (!rst) begin
            load_timing(chip);
            mh      = 0;
            mv      = 0;
            mhb     = 1'b0;
            exp_hs  = 1'b0;
            exp_vs  = 1'b0;
            exp_act = 1'b0;
            armed   = 1'b1;
        end else begin
            line_len = mw + 1;
            pos      = mv * line_len + mh;  // position within the frame
            hs_on    = mh >= hs_sta && mh < hs_end;
            vs_on    = pos >= vs_sta * line_len + hs_sta && pos < vs_end * line_len + hs_end;
            if (chip_q[0])
                v_on = mv >= va_sta && mv <= va_end;  // pal window inside the frame
            else
                v_on = mv < va_end || mv >= va_sta;   // ntsc window wraps past line 0
            exp_act = mh > ha_sta && mh <= ha_end && v_on;
            exp_hs  = (enable_csync ? (hs_on | vs_on) : hs_on) ~^ hpolarity;
            exp_vs  = enable_csync ? 1'b0 : (vs_on ~^ vpolarity);
            if (mh < mw) begin
                mh++;
            end else begin
                mh = 0;  // next output line
                if (mv < mhgt) begin
                    mv++;
                    mhb = !mhb;
                end else begin
                    mv  = 0;
                    mhb = 1'b0;
                end
            end
        end
    end

    // compare half a cycle later once all registers settle
    always @(negedge clk_dvi) begin
        if (armed) begin
            cyc_count++;
            check_value("hsync", {3'b0, exp_hs}, {3'b0, hsync});
            check_value("vsync", {3'b0, exp_vs}, {3'b0, vsync});
            check_value("active", {3'b0, exp_act}, {3'b0, active});
            check_value("half_bright", {3'b0, mhb}, {3'b0, half_bright});
            if (exp_ok) begin
                pix_count++;
                check_value("pixel_color", exp_pix, pixel_color);
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/dvi_scaler_props.sv ====
// bound into sync_gen; needs a run with assertions enabled, clock must run from time 0
`timescale 1ns/1ps
`default_nettype none

module dvi_scaler_props import dvi_timing_pkg::*; (
    input logic     clk_dvi,
    input logic     rst,
    input logic     enable_csync,
    input h_count_t h_count,
    input h_count_t hs_sta,
    input h_count_t hs_end,
    input logic     hsync,
    input logic     vsync,
    input logic     half_bright
);

    logic started;  // masks the first edge with no history yet

    always_ff @(posedge clk_dvi) begin
        started <= 1'b1;
    end

    // sync outputs move only on the edge after h_count sat on a sync edge
    a_sync_on_step: assert property (@(posedge clk_dvi) disable iff (!rst)
        $changed({hsync, vsync}) |->
            !$past(rst, 2) || ($past(h_count) == hs_sta) || ($past(h_count) == hs_end))
        else $error("sync output changed away from a sync window edge");

    // reset clears the dim line flag
    a_half_bright_reset: assert property (@(posedge clk_dvi)
        started && !$past(rst) |-> !half_bright)
        else $error("half_bright set right after reset");

    // composite mode keeps vsync parked low
    a_csync_vsync_low: assert property (@(posedge clk_dvi)
        started && $past(enable_csync) |-> !vsync)
        else $error("vsync active while composite sync is on");

endmodule

bind sync_gen dvi_scaler_props i_props (
    .clk_dvi      (clk_dvi),
    .rst          (rst),
    .enable_csync (enable_csync),
    .h_count      (h_count),
    .hs_sta       (timing.hs_sta),
    .hs_end       (timing.hs_end),
    .hsync        (hsync),
    .vsync        (vsync),
    .half_bright  (half_bright)
);

`default_nettype wire

// ==== src/dvi_scaler_top.sv ====
// single clk_dvi domain; native pixels must arrive already synchronised to clk_dvi
`timescale 1ns/1ps
`default_nettype none

module dvi_scaler_top
    import dvi_timing_pkg::*;
    import video_pixel_pkg::*;
#(
    parameter int addr_width = $bits(line_addr_t),
    parameter int data_width = $bits(color_t)
) (
    input  logic                  clk_dvi,
    input  logic                  rst,
    input  chip_t                 chip,            // change only in reset
    input  logic                  hpolarity,
    input  logic                  vpolarity,
    input  logic                  enable_csync,
    input  logic                  pixel_valid,
    input  raster_x_t             raster_x,
    input  logic [data_width-1:0] pixel_color_in,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  active,
    output logic [data_width-1:0] pixel_color,
    output logic                  half_bright
);

    h_count_t h_count;  // output x for the readout address

    video_timing_if i_timing ();

    chip_timing_table i_table (
        .clk_dvi (clk_dvi),
        .rst     (rst),
        .chip    (chip),
        .timing  (i_timing)
    );

    sync_gen i_sync (
        .clk_dvi      (clk_dvi),
        .rst          (rst),
        .hpolarity    (hpolarity),
        .vpolarity    (vpolarity),
        .enable_csync (enable_csync),
        .timing       (i_timing),
        .h_count      (h_count),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (active),
        .half_bright  (half_bright)
    );

    line_double_buffer #(
        .addr_width (addr_width),
        .data_width (data_width)
    ) i_linebuf (
        .clk_dvi        (clk_dvi),
        .rst            (rst),
        .pixel_valid    (pixel_valid),
        .raster_x       (raster_x),
        .pixel_color_in (pixel_color_in),
        .h_count        (h_count),
        .timing         (i_timing),
        .pixel_color    (pixel_color)
    );

endmodule

`default_nettype wire

// ==== src/line_double_buffer.sv ====
// output is always one native line behind; only addresses written this line are valid
`timescale 1ns/1ps
`default_nettype none

module line_double_buffer
    import dvi_timing_pkg::*;
    import video_pixel_pkg::*;
#(
    parameter int addr_width = 11,
    parameter int data_width = 4
) (
    input  logic                  clk_dvi,
    input  logic                  rst,
    input  logic                  pixel_valid,     // one native pixel strobe
    input  raster_x_t             raster_x,
    input  logic [data_width-1:0] pixel_color_in,
    input  h_count_t              h_count,
    video_timing_if.offset_sink   timing,
    output logic [data_width-1:0] pixel_color      // two cycles after h_count
);

    logic                  wr_buf_q;  // buffer being filled
    logic                  wr_buf;    // including a swap this cycle
    logic                  swap;
    logic                  rd_buf_q;  // read select, aligned to ram dout
    logic [addr_width-1:0] wr_addr;
    logic [addr_width-1:0] rd_addr;
    logic [1:0]            we;
    logic [1:0]            re;
    logic [addr_width-1:0] addr [2];
    logic [data_width-1:0] dout [2];

    // ------------------------------------------------------------
    // buffer swap at native line start
    // ------------------------------------------------------------
    assign swap   = pixel_valid && (raster_x == '0);
    assign wr_buf = wr_buf_q ^ swap;  // pixel 0 lands in the new buffer

    always_ff @(posedge clk_dvi) begin
        if (!rst)
            wr_buf_q <= 1'b0;
        else
            wr_buf_q <= wr_buf;
    end

    assign wr_addr = addr_width'(raster_x);
    assign rd_addr = addr_width'(h_count + timing.x_offset);  // skip left border

    for (genvar i = 0; i < 2; i++) begin : g_buf
        assign we[i]   = pixel_valid && (wr_buf == 1'(i));
        assign re[i]   = wr_buf != 1'(i);  // the other one is read out
        assign addr[i] = (wr_buf == 1'(i)) ? wr_addr : rd_addr;

        line_ram #(
            .addr_width (addr_width),
            .data_width (data_width)
        ) i_ram (
            .clk_dvi (clk_dvi),
            .we      (we[i]),
            .addr    (addr[i]),
            .din     (pixel_color_in),
            .re      (re[i]),
            .dout    (dout[i])
        );
    end

    // ram latency 1, output register 1
    always_ff @(posedge clk_dvi) begin
        rd_buf_q    <= ~wr_buf;
        pixel_color <= dout[rd_buf_q];
    end

endmodule

`default_nettype wire

// ==== src/line_ram.sv ====
// single address port; reads and writes of one cycle share addr
`timescale 1ns/1ps
`default_nettype none

module line_ram #(
    parameter int addr_width = 11,
    parameter int data_width = 4
) (
    input  logic                  clk_dvi,
    input  logic                  we,
    input  logic [addr_width-1:0] addr,
    input  logic [data_width-1:0] din,
    input  logic                  re,
    output logic [data_width-1:0] dout   // valid one cycle after re
);

    logic [data_width-1:0] mem [2**addr_width];  // one raster line

    always_ff @(posedge clk_dvi) begin
        if (we)
            mem[addr] <= din;
        if (re)
            dout <= mem[addr];  // holds while not reading
    end

endmodule

`default_nettype wire

// ==== src/sync_gen.sv ====
// sync windows are not standard vesa timings; outputs lag h_count by one clk_dvi
`timescale 1ns/1ps
`default_nettype none

module sync_gen import dvi_timing_pkg::*; (
    input  logic     clk_dvi,
    input  logic     rst,
    input  logic     hpolarity,     // 1 = active high
    input  logic     vpolarity,
    input  logic     enable_csync,  // composite on hsync
    video_timing_if.sink timing,
    output h_count_t h_count,
    output logic     hsync,
    output logic     vsync,
    output logic     active,
    output logic     half_bright
);

    v_count_t v_count;
    logic     hs_win;        // active-high windows
    logic     vs_win;
    logic     cs_win;
    logic     hs_lvl;        // with polarity applied
    logic     vs_lvl;
    logic     cs_lvl;
    logic     is_pal;
    logic     h_blank;
    logic     v_blank_pal;
    logic     v_blank_ntsc;

    // ------------------------------------------------------------
    // output raster counters
    // ------------------------------------------------------------
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            h_count     <= '0;
            v_count     <= '0;
            half_bright <= 1'b0;
        end else if (h_count < timing.max_width) begin
            h_count <= h_count + 11'd1;
        end else begin
            h_count <= '0;  // end of output line
            if (v_count < timing.max_height) begin
                v_count     <= v_count + 10'd1;
                half_bright <= ~half_bright;  // every second line dimmed
            end else begin
                v_count     <= '0;
                half_bright <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------
    // sync and blanking windows
    // ------------------------------------------------------------
    assign hs_win = (h_count >= timing.hs_sta) && (h_count < timing.hs_end);
    // from (vs_sta, hs_sta) up to (vs_end, hs_end)
    assign vs_win = ((v_count == timing.vs_end && h_count < timing.hs_end) ||
                     v_count < timing.vs_end) &&
                    ((v_count == timing.vs_sta && h_count >= timing.hs_sta) ||
                     v_count > timing.vs_sta);
    assign cs_win = hs_win | vs_win;

    assign hs_lvl = hpolarity ? hs_win : ~hs_win;
    assign vs_lvl = vpolarity ? vs_win : ~vs_win;
    assign cs_lvl = hpolarity ? cs_win : ~cs_win;  // csync follows hpolarity

    // pal window sits inside the frame, ntsc wraps through line 0
    assign is_pal  = timing.va_sta < timing.va_end;
    assign h_blank = (h_count > timing.ha_end) || (h_count <= timing.ha_sta);
    assign v_blank_pal  = (v_count < timing.va_sta) ||
                          ((v_count != timing.va_end || h_count < timing.ha_sta) &&
                           v_count >= timing.va_end);
    assign v_blank_ntsc = (v_count >= timing.va_end) &&
                          ((v_count == timing.va_sta && h_count < timing.ha_sta) ||
                           v_count < timing.va_sta);

    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            active <= 1'b0;
        end else begin
            hsync  <= enable_csync ? cs_lvl : hs_lvl;
            vsync  <= enable_csync ? 1'b0 : vs_lvl;  // unused in csync mode
            active <= ~(h_blank | (is_pal ? v_blank_pal : v_blank_ntsc));
        end
    end

endmodule

`default_nettype wire

// ==== src/chip_timing_table.sv ====
// chip is sampled only while rst is low; the window set is frozen once out of reset
`timescale 1ns/1ps
`default_nettype none

module chip_timing_table import dvi_timing_pkg::*; (
    input  logic  clk_dvi,
    input  logic  rst,
    input  chip_t chip,
    video_timing_if.source timing
);

    // one cycle from chip to window set
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin  // load during reset, hold afterwards
            case (chip)
                chip_6569r1, chip_6569r3: begin  // both pal revs share timing
                    timing.max_width  <= pal_max_width;
                    timing.max_height <= pal_max_height;
                    timing.hs_sta     <= pal_hs_sta;
                    timing.hs_end     <= pal_hs_end;
                    timing.ha_sta     <= pal_ha_sta;
                    timing.ha_end     <= pal_ha_end;
                    timing.vs_sta     <= pal_vs_sta;
                    timing.vs_end     <= pal_vs_end;
                    timing.va_sta     <= pal_va_sta;
                    timing.va_end     <= pal_va_end;
                    timing.x_offset   <= pal_x_offset;
                end
                chip_6567r8: begin
                    timing.max_width  <= ntsc_r8_max_width;
                    timing.max_height <= ntsc_r8_max_height;
                    timing.hs_sta     <= ntsc_r8_hs_sta;
                    timing.hs_end     <= ntsc_r8_hs_end;
                    timing.ha_sta     <= ntsc_r8_ha_sta;
                    timing.ha_end     <= ntsc_r8_ha_end;
                    timing.vs_sta     <= ntsc_r8_vs_sta;
                    timing.vs_end     <= ntsc_r8_vs_end;
                    timing.va_sta     <= ntsc_r8_va_sta;
                    timing.va_end     <= ntsc_r8_va_end;
                    timing.x_offset   <= ntsc_r8_x_offset;
                end
                default: begin  // 6567r56a
                    timing.max_width  <= ntsc_r56_max_width;
                    timing.max_height <= ntsc_r56_max_height;
                    timing.hs_sta     <= ntsc_r56_hs_sta;
                    timing.hs_end     <= ntsc_r56_hs_end;
                    timing.ha_sta     <= ntsc_r56_ha_sta;
                    timing.ha_end     <= ntsc_r56_ha_end;
                    timing.vs_sta     <= ntsc_r56_vs_sta;
                    timing.vs_end     <= ntsc_r56_vs_end;
                    timing.va_sta     <= ntsc_r56_va_sta;
                    timing.va_end     <= ntsc_r56_va_end;
                    timing.x_offset   <= ntsc_r56_x_offset;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/video_timing_if.sv ====
// window edges are in output pixels/lines; hs/ha ranges must not straddle h_count 0
`timescale 1ns/1ps
`default_nettype none

interface video_timing_if import dvi_timing_pkg::*; ();

    h_count_t max_width;   // last h_count of a line
    v_count_t max_height;  // last v_count of a frame
    h_count_t hs_sta;
    h_count_t hs_end;
    h_count_t ha_sta;
    h_count_t ha_end;
    v_count_t vs_sta;
    v_count_t vs_end;
    v_count_t va_sta;      // above va_end on ntsc, window wraps
    v_count_t va_end;
    h_count_t x_offset;    // skips part of the left border

    modport source (
        output max_width, max_height, hs_sta, hs_end, ha_sta, ha_end,
        output vs_sta, vs_end, va_sta, va_end, x_offset
    );

    modport sink (
        input max_width, max_height, hs_sta, hs_end, ha_sta, ha_end,
        input vs_sta, vs_end, va_sta, va_end
    );

    modport offset_sink (input x_offset);

endinterface

`default_nettype wire

// ==== src/video_pixel_pkg.sv ====
// native pixel side; colour is a 4-bit palette index, x is the native raster x
`default_nettype none

package video_pixel_pkg;

    localparam int color_width     = 4;   // palette index
    localparam int raster_x_width  = 10;  // native x, below 520
    localparam int line_addr_width = 11;  // covers h_count plus x_offset

    typedef logic [color_width-1:0]     color_t;
    typedef logic [raster_x_width-1:0]  raster_x_t;
    typedef logic [line_addr_width-1:0] line_addr_t;

endpackage

`default_nettype wire

// ==== src/dvi_timing_pkg.sv ====
// fixed reduced-width dvi timings only (pal 29 MHz, ntsc 26 MHz); no runtime timing registers
`default_nettype none

package dvi_timing_pkg;

    typedef logic [10:0] h_count_t;  // output x, one clk_dvi per pixel
    typedef logic [9:0]  v_count_t;  // output y, two per native line

    // bit 0 set means a pal part
    typedef enum logic [1:0] {
        chip_6567r8   = 2'd0,
        chip_6569r3   = 2'd1,
        chip_6567r56a = 2'd2,
        chip_6569r1   = 2'd3
    } chip_t;

    // ------------------------------------------------------------
    // 6569 pal, 945 x 624, 782x576 visible
    // ------------------------------------------------------------
    localparam h_count_t pal_max_width  = 11'd944;
    localparam v_count_t pal_max_height = 10'd623;
    localparam h_count_t pal_x_offset   = 11'd70;
    localparam h_count_t pal_hs_sta     = 11'd0;   // front porch wraps past 944
    localparam h_count_t pal_hs_end     = 11'd64;
    localparam h_count_t pal_ha_sta     = 11'd132;
    localparam h_count_t pal_ha_end     = 11'd914;
    localparam v_count_t pal_vs_sta     = 10'd7;
    localparam v_count_t pal_vs_end     = 10'd12;
    localparam v_count_t pal_va_sta     = 10'd17;
    localparam v_count_t pal_va_end     = 10'd592;  // 576 lines

    // ------------------------------------------------------------
    // 6567r8 and 6567r56a ntsc, 480 visible lines
    // ------------------------------------------------------------
    localparam h_count_t ntsc_r8_max_width   = 11'd844;
    localparam v_count_t ntsc_r8_max_height  = 10'd525;
    localparam h_count_t ntsc_r8_x_offset    = 11'd131;
    localparam h_count_t ntsc_r8_hs_sta      = 11'd11;
    localparam h_count_t ntsc_r8_hs_end      = 11'd75;
    localparam h_count_t ntsc_r8_ha_sta      = 11'd106;
    localparam h_count_t ntsc_r8_ha_end      = 11'd826;
    localparam v_count_t ntsc_r8_vs_sta      = 10'd28;
    localparam v_count_t ntsc_r8_vs_end      = 10'd50;
    localparam v_count_t ntsc_r8_va_sta      = 10'd72;  // vertical window wraps
    localparam v_count_t ntsc_r8_va_end      = 10'd26;

    localparam h_count_t ntsc_r56_max_width  = 11'd831;
    localparam v_count_t ntsc_r56_max_height = 10'd523;
    localparam h_count_t ntsc_r56_x_offset   = 11'd139;
    localparam h_count_t ntsc_r56_hs_sta     = 11'd2;
    localparam h_count_t ntsc_r56_hs_end     = 11'd66;
    localparam h_count_t ntsc_r56_ha_sta     = 11'd90;
    localparam h_count_t ntsc_r56_ha_end     = 11'd814;
    localparam v_count_t ntsc_r56_vs_sta     = 10'd28;
    localparam v_count_t ntsc_r56_vs_end     = 10'd50;
    localparam v_count_t ntsc_r56_va_sta     = 10'd70;
    localparam v_count_t ntsc_r56_va_end     = 10'd26;

endpackage

`default_nettype wire
